/* common/csr_defines.svh */
//////////////////////////////////////////////////////////////////////
// data widths, CSR address map, mstatus and mcause bit positions
// and performance counter indices
//////////////////////////////////////////////////////////////////////
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// widths
`define CSR_XLEN    32
`define CSR_ADDR_W  12
`define TVEC_W      24
`define CAUSE_W     6
`define N_PERF_CNT  8
`define PERF_IDX_W  3

// machine trap registers
`define CSR_MSTATUS    12'h300
`define CSR_MTVEC      12'h305
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342

// performance counter block, 0x780 up to 0x79F
`define CSR_PCER       12'h7A0
`define CSR_PCMR       12'h7A1
`define CSR_PCCR_BASE  12'h780
`define CSR_PCCR_ALL   12'h79F

// field positions in the read word
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7
`define MCAUSE_IRQ_BIT    31

// counter slots
`define PERF_CYCLES        0
`define PERF_INSTR         1
`define PERF_LD_STALL      2
`define PERF_IMISS         3
`define PERF_LOAD          4
`define PERF_STORE         5
`define PERF_BRANCH        6
`define PERF_BRANCH_TAKEN  7

`endif

/* common/csr_pkg.sv */
//////////////////////////////////////////////////////////////////////
// CSR op encoding plus request, select, write command, trap and
// pipeline event structs
//////////////////////////////////////////////////////////////////////
`include "csr_defines.svh"

package csr_pkg;

  // op field of a CSR instruction
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // request from the core, same cycle read
  typedef struct packed {
    logic                   access;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_XLEN-1:0]   wdata;
    csr_op_e                op;
  } csr_req_t;

  // one-hot register select out of the address decoder
  typedef struct packed {
    logic mstatus;
    logic mepc;
    logic mcause;
    logic mtvec;
    logic pcer;
    logic pcmr;
    logic pccr_one;
    logic pccr_all;
  } csr_sel_t;

  // write command to the register blocks
  // wdata already holds the result of the op
  typedef struct packed {
    logic                   we;
    csr_sel_t               sel;
    logic [`PERF_IDX_W-1:0] idx;
    logic [`CSR_XLEN-1:0]   wdata;
  } csr_wr_t;

  // trap entry and return from the controller
  typedef struct packed {
    logic                 save_cause;
    logic [`CAUSE_W-1:0]  cause;
    logic                 save_if;
    logic                 save_id;
    logic                 load_event;
    logic [`CSR_XLEN-1:0] pc_if;
    logic [`CSR_XLEN-1:0] pc_id;
    logic [`CSR_XLEN-1:0] pc_ex;
    logic                 mret;
  } trap_req_t;

  // raw core status for the counters
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic ld_stall;
    logic imiss;
    logic pc_set;
    logic mem_load;
    logic mem_store;
    logic branch;
    logic branch_taken;
  } perf_evt_t;

endpackage

/* verilog/csr_access.sv */
//////////////////////////////////////////////////////////////////////
// CSR address decode, read data mux and write/set/clear value
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_access import csr_pkg::*; (
  input  csr_req_t             csr_req_i,
  input  logic [`CSR_XLEN-1:0] trap_rdata_i,
  input  logic [`CSR_XLEN-1:0] perf_rdata_i,
  output csr_wr_t              csr_wr_o,
  output logic [`CSR_XLEN-1:0] csr_rdata_o
);

  csr_sel_t                sel;
  logic [`PERF_IDX_W-1:0]  cnt_idx;
  logic [`CSR_XLEN-1:0]    wdata_mod;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  // nothing selected while access is low
  always_comb begin
    sel     = '0;
    cnt_idx = '0;
    if (csr_req_i.access) begin
      case (csr_req_i.addr)
        `CSR_MSTATUS:  sel.mstatus  = 1'b1;
        `CSR_MTVEC:    sel.mtvec    = 1'b1;
        `CSR_MEPC:     sel.mepc     = 1'b1;
        `CSR_MCAUSE:   sel.mcause   = 1'b1;
        `CSR_PCER:     sel.pcer     = 1'b1;
        `CSR_PCMR:     sel.pcmr     = 1'b1;
        `CSR_PCCR_ALL: sel.pccr_all = 1'b1;
        default: begin
          // only the implemented counters, rest of 0x78x reads zero
          if (csr_req_i.addr >= `CSR_PCCR_BASE &&
              csr_req_i.addr < `CSR_PCCR_BASE + `N_PERF_CNT) begin
            sel.pccr_one = 1'b1;
            // base is aligned, low bits are the counter number
            cnt_idx      = csr_req_i.addr[`PERF_IDX_W-1:0];
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux and op
  //////////////////////////////////////////////////////////////////////

  // select is one-hot, group flags pick the block
  always_comb begin
    if (sel.mstatus | sel.mepc | sel.mcause | sel.mtvec)
      csr_rdata_o = trap_rdata_i;
    else if (sel.pcer | sel.pcmr | sel.pccr_one | sel.pccr_all)
      csr_rdata_o = perf_rdata_i;
    else
      csr_rdata_o = '0;
  end

  // new value from old value and request data
  always_comb begin
    case (csr_req_i.op)
      CSR_OP_SET:   wdata_mod = csr_req_i.wdata | csr_rdata_o;
      CSR_OP_CLEAR: wdata_mod = csr_rdata_o & ~csr_req_i.wdata;
      default:      wdata_mod = csr_req_i.wdata;
    endcase
  end

  assign csr_wr_o = '{
    we:    csr_req_i.access & (csr_req_i.op != CSR_OP_NONE),
    sel:   sel,
    idx:   cnt_idx,
    wdata: wdata_mod
  };

endmodule

/* trap/trap_csrs.sv */
//////////////////////////////////////////////////////////////////////
// mstatus (mie, mpie), mepc and mcause with trap entry and MRET
// mtvec read path from the boot address
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module trap_csrs import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_wr_t              csr_wr_i,
  input  trap_req_t            trap_req_i,
  input  logic [`TVEC_W-1:0]   boot_addr_i,
  output logic [`CSR_XLEN-1:0] rdata_o,
  output logic [`CSR_XLEN-1:0] epc_o,
  output logic [`TVEC_W-1:0]   tvec_o,
  output logic                 irq_enable_o
);

  logic                 mie_q, mie_n;
  logic                 mpie_q, mpie_n;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_n;
  logic [`CAUSE_W-1:0]  mcause_q, mcause_n;
  logic [`CSR_XLEN-1:0] exc_pc;

  // read formatting, zero when no trap register is selected
  always_comb begin
    rdata_o = '0;
    if (csr_wr_i.sel.mstatus) begin
      rdata_o[`MSTATUS_MIE_BIT]  = mie_q;
      rdata_o[`MSTATUS_MPIE_BIT] = mpie_q;
    end else if (csr_wr_i.sel.mepc) begin
      rdata_o = mepc_q;
    end else if (csr_wr_i.sel.mcause) begin
      // interrupt flag moves up to the msb
      rdata_o[`MCAUSE_IRQ_BIT]   = mcause_q[`CAUSE_W-1];
      rdata_o[`CAUSE_W-2:0]      = mcause_q[`CAUSE_W-2:0];
    end else if (csr_wr_i.sel.mtvec) begin
      rdata_o = {boot_addr_i, {(`CSR_XLEN-`TVEC_W){1'b0}}};
    end
  end

  // faulting pc, load event in EX wins
  // save_id and no flag at all both give the decode pc
  always_comb begin
    if (trap_req_i.load_event)
      exc_pc = trap_req_i.pc_ex;
    else if (trap_req_i.save_if)
      exc_pc = trap_req_i.pc_if;
    else
      exc_pc = trap_req_i.pc_id;
  end

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    // csr instruction writes first
    if (csr_wr_i.we) begin
      if (csr_wr_i.sel.mstatus) begin
        mie_n  = csr_wr_i.wdata[`MSTATUS_MIE_BIT];
        mpie_n = csr_wr_i.wdata[`MSTATUS_MPIE_BIT];
      end
      if (csr_wr_i.sel.mepc)
        mepc_n = csr_wr_i.wdata;
      // same layout as the read word so read-modify-write keeps the flag
      if (csr_wr_i.sel.mcause)
        mcause_n = {csr_wr_i.wdata[`MCAUSE_IRQ_BIT], csr_wr_i.wdata[`CAUSE_W-2:0]};
    end

    // trap controller overrides the csr write
    if (trap_req_i.save_cause) begin
      mpie_n   = mie_q;
      mie_n    = 1'b0;
      mepc_n   = exc_pc;
      mcause_n = trap_req_i.cause;
    end else if (trap_req_i.mret) begin
      mie_n    = mpie_q;
      mpie_n   = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  // straight to the controller
  assign epc_o        = mepc_q;
  assign tvec_o       = boot_addr_i;
  assign irq_enable_o = mie_q;

endmodule

/* perf/perf_events.sv */
//////////////////////////////////////////////////////////////////////
// per-cycle event vector for the performance counters
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module perf_events import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  perf_evt_t              perf_evt_i,
  output logic [`N_PERF_CNT-1:0] events_o
);

  // ID stage finished in the previous cycle
  logic id_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      id_valid_q <= 1'b0;
    else
      id_valid_q <= perf_evt_i.id_valid;
  end

  always_comb begin
    events_o                     = '0;
    events_o[`PERF_CYCLES]       = 1'b1;
    events_o[`PERF_INSTR]        = perf_evt_i.id_valid & perf_evt_i.is_decoding;
    // stall and branch counted once per retired ID slot
    events_o[`PERF_LD_STALL]     = perf_evt_i.ld_stall & id_valid_q;
    // fetch wait without jumps and branches
    events_o[`PERF_IMISS]        = perf_evt_i.imiss & ~perf_evt_i.pc_set;
    events_o[`PERF_LOAD]         = perf_evt_i.mem_load;
    events_o[`PERF_STORE]        = perf_evt_i.mem_store;
    events_o[`PERF_BRANCH]       = perf_evt_i.branch & id_valid_q;
    events_o[`PERF_BRANCH_TAKEN] = perf_evt_i.branch & perf_evt_i.branch_taken & id_valid_q;
  end

endmodule

/* perf/perf_counters.sv */
//////////////////////////////////////////////////////////////////////
// performance counters with event enable (PCER) and mode (PCMR)
// registers, optional saturation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module perf_counters import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`N_PERF_CNT-1:0] events_i,
  input  csr_wr_t                csr_wr_i,
  output logic [`CSR_XLEN-1:0]   rdata_o
);

  logic [`N_PERF_CNT-1:0]                 pcer_q, pcer_n;
  // bit 0 global enable, bit 1 saturate
  logic [1:0]                             pcmr_q, pcmr_n;
  logic [`N_PERF_CNT-1:0]                 inc, inc_q;
  logic [`N_PERF_CNT-1:0][`CSR_XLEN-1:0]  cnt_q, cnt_n;

  // increment request, applied one edge later
  assign inc = events_i & pcer_q & {`N_PERF_CNT{pcmr_q[0]}};

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `N_PERF_CNT; i++) begin
      cnt_n[i] = cnt_q[i];
      // all-ones sticks in saturate mode
      if (inc_q[i] && (cnt_q[i] != '1 || !pcmr_q[1]))
        cnt_n[i] = cnt_q[i] + `CSR_XLEN'(1);
      // csr write beats the increment
      if (csr_wr_i.we && (csr_wr_i.sel.pccr_all ||
          (csr_wr_i.sel.pccr_one && csr_wr_i.idx == `PERF_IDX_W'(i))))
        cnt_n[i] = csr_wr_i.wdata;
    end
  end

  always_comb begin
    pcer_n = pcer_q;
    pcmr_n = pcmr_q;
    if (csr_wr_i.we && csr_wr_i.sel.pcer)
      pcer_n = csr_wr_i.wdata[`N_PERF_CNT-1:0];
    if (csr_wr_i.we && csr_wr_i.sel.pcmr)
      pcmr_n = csr_wr_i.wdata[1:0];
  end

  // read back, the all-counter alias reads zero
  always_comb begin
    rdata_o = '0;
    if (csr_wr_i.sel.pcer)
      rdata_o = {{(`CSR_XLEN-`N_PERF_CNT){1'b0}}, pcer_q};
    else if (csr_wr_i.sel.pcmr)
      rdata_o = {{(`CSR_XLEN-2){1'b0}}, pcmr_q};
    else if (csr_wr_i.sel.pccr_one)
      rdata_o = cnt_q[csr_wr_i.idx];
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      // counting and saturation on out of reset
      pcmr_q <= 2'b11;
      inc_q  <= '0;
      cnt_q  <= '0;
    end else begin
      pcer_q <= pcer_n;
      pcmr_q <= pcmr_n;
      inc_q  <= inc;
      cnt_q  <= cnt_n;
    end
  end

endmodule

/* verilog/csr_top.sv */
//////////////////////////////////////////////////////////////////////
// machine-mode CSR file, top level
// access decode, trap registers, event conditioning and counters
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_top import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`TVEC_W-1:0]   boot_addr_i,
  input  csr_req_t             csr_req_i,
  input  trap_req_t            trap_req_i,
  input  perf_evt_t            perf_evt_i,
  output logic [`CSR_XLEN-1:0] csr_rdata_o,
  output logic [`CSR_XLEN-1:0] epc_o,
  output logic [`TVEC_W-1:0]   tvec_o,
  output logic                 irq_enable_o
);

  // shared write command, fans out to both register blocks
  csr_wr_t                 csr_wr;
  // read words back from the register blocks
  logic [`CSR_XLEN-1:0]    trap_rdata;
  logic [`CSR_XLEN-1:0]    perf_rdata;
  // conditioned event vector
  logic [`N_PERF_CNT-1:0]  events;

  csr_access i_csr_access (
    .csr_req_i    (csr_req_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .csr_wr_o     (csr_wr),
    .csr_rdata_o  (csr_rdata_o)
  );

  trap_csrs i_trap_csrs (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_i     (csr_wr),
    .trap_req_i   (trap_req_i),
    .boot_addr_i  (boot_addr_i),
    .rdata_o      (trap_rdata),
    .epc_o        (epc_o),
    .tvec_o       (tvec_o),
    .irq_enable_o (irq_enable_o)
  );

  perf_events i_perf_events (
    .clk        (clk),
    .rst_n      (rst_n),
    .perf_evt_i (perf_evt_i),
    .events_o   (events)
  );

  perf_counters i_perf_counters (
    .clk      (clk),
    .rst_n    (rst_n),
    .events_i (events),
    .csr_wr_i (csr_wr),
    .rdata_o  (perf_rdata)
  );

endmodule

/* verification/csr_asserts.sv */
//////////////////////////////////////////////////////////////////////
// concurrent checks on the CSR top level, bound into csr_top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_asserts import csr_pkg::*; (
  input logic               clk,
  input logic               rst_n,
  input logic [`TVEC_W-1:0] boot_addr_i,
  input logic [`TVEC_W-1:0] tvec_o,
  input logic               irq_enable_o,
  input trap_req_t          trap_req_i
);

  // failures so far, picked up by the testbench at the end
  int fail_count = 0;

  // interrupts masked in the first cycle out of reset
  a_irq_off_after_reset : assert property (@(posedge clk) $rose(rst_n) |-> !irq_enable_o)
    else begin
      fail_count++;
      $error("irq_enable_o high in the first cycle after reset release");
    end

  // trap vector is the boot address, always
  a_tvec_is_boot : assert property (@(posedge clk) tvec_o == boot_addr_i)
    else begin
      fail_count++;
      $error("tvec_o differs from boot_addr_i");
    end

  // trap entry clears mie at the next edge
  a_trap_masks_irq : assert property (@(posedge clk) disable iff (!rst_n)
                                      trap_req_i.save_cause |=> !irq_enable_o)
    else begin
      fail_count++;
      $error("irq_enable_o still high after a save_cause cycle");
    end

endmodule

bind csr_top csr_asserts i_csr_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .boot_addr_i  (boot_addr_i),
  .tvec_o       (tvec_o),
  .irq_enable_o (irq_enable_o),
  .trap_req_i   (trap_req_i)
);

/* verification/csr_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the CSR file: step table, clock and reset,
// readback checks against a small reference model, timeout
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_tb import csr_pkg::*; ();

  // what a step compares after its inputs settle
  localparam int CHK_NONE  = 0;
  localparam int CHK_RDATA = 1;
  localparam int CHK_IRQ   = 2;
  localparam int CHK_EPC   = 3;

  localparam logic [`TVEC_W-1:0]   BOOT_ADDR = 24'h1C0080;
  localparam logic [`CSR_XLEN-1:0] PC_EX     = 32'h0000_4A10;
  localparam int                   N_LOADS   = 5;

  logic                 clk;
  logic                 rst_n;
  logic [`TVEC_W-1:0]   boot_addr;
  csr_req_t             csr_req;
  trap_req_t            trap_req;
  perf_evt_t            perf_evt;
  logic [`CSR_XLEN-1:0] csr_rdata;
  logic [`CSR_XLEN-1:0] epc;
  logic [`TVEC_W-1:0]   tvec;
  logic                 irq_enable;

  // step table, one entry per cycle
  csr_req_t             tab_req[$];
  trap_req_t            tab_trap[$];
  perf_evt_t            tab_evt[$];
  int                   tab_chk[$];
  logic [`CSR_XLEN-1:0] tab_exp[$];
  string                tab_name[$];

  int                   errors;
  int                   checks;
  int                   cycles;
  int                   max_cycles;
  integer               seed;
  // expected mepc while the table is built
  logic [`CSR_XLEN-1:0] mepc_model;

  csr_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .boot_addr_i  (boot_addr),
    .csr_req_i    (csr_req),
    .trap_req_i   (trap_req),
    .perf_evt_i   (perf_evt),
    .csr_rdata_o  (csr_rdata),
    .epc_o        (epc),
    .tvec_o       (tvec),
    .irq_enable_o (irq_enable)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and table helpers
  //////////////////////////////////////////////////////////////////////

  // write, set and clear on the old value
  function automatic logic [`CSR_XLEN-1:0] op_result(input csr_op_e op,
                                                     input logic [`CSR_XLEN-1:0] old_val,
                                                     input logic [`CSR_XLEN-1:0] data);
    case (op)
      CSR_OP_WRITE: return data;
      CSR_OP_SET:   return old_val | data;
      CSR_OP_CLEAR: return old_val & ~data;
      default:      return old_val;
    endcase
  endfunction

  function automatic csr_req_t csr_cmd(input logic [`CSR_ADDR_W-1:0] addr,
                                       input logic [`CSR_XLEN-1:0] wdata, input csr_op_e op);
    csr_req_t req;
    req.access = 1'b1;
    req.addr   = addr;
    req.wdata  = wdata;
    req.op     = op;
    return req;
  endfunction

  task automatic add_step(input csr_req_t req, input trap_req_t trap, input perf_evt_t evt,
                          input int chk, input logic [`CSR_XLEN-1:0] exp, input string name);
    tab_req.push_back(req);
    tab_trap.push_back(trap);
    tab_evt.push_back(evt);
    tab_chk.push_back(chk);
    tab_exp.push_back(exp);
    tab_name.push_back(name);
  endtask

  // CSR access alone, trap and events idle
  task automatic add_csr(input string name, input logic [`CSR_ADDR_W-1:0] addr,
                         input logic [`CSR_XLEN-1:0] wdata, input csr_op_e op,
                         input int chk, input logic [`CSR_XLEN-1:0] exp);
    add_step(csr_cmd(addr, wdata, op), '0, '0, chk, exp, name);
  endtask

  task automatic add_idle(input string name, input int chk, input logic [`CSR_XLEN-1:0] exp);
    add_step('0, '0, '0, chk, exp, name);
  endtask

  // op on mepc with random data, old value visible in the same cycle
  task automatic add_mepc_op(input string name, input csr_op_e op);
    logic [`CSR_XLEN-1:0] data;
    data = $random(seed);
    add_csr({name, "_op"}, `CSR_MEPC, data, op, CHK_RDATA, mepc_model);
    mepc_model = op_result(op, mepc_model, data);
    add_csr({name, "_readback"}, `CSR_MEPC, '0, CSR_OP_NONE, CHK_RDATA, mepc_model);
  endtask

  task automatic build_table();
    csr_req_t             req;
    trap_req_t            trap;
    perf_evt_t            evt;
    logic [`CSR_ADDR_W-1:0] cyc_addr;
    cyc_addr   = `CSR_ADDR_W'(`CSR_PCCR_BASE + `PERF_CYCLES);
    mepc_model = '0;
    // writes and readback
    add_mepc_op("mepc_write", CSR_OP_WRITE);
    add_mepc_op("mepc_set", CSR_OP_SET);
    add_mepc_op("mepc_clear", CSR_OP_CLEAR);
    add_csr("mtvec_read", `CSR_MTVEC, '0, CSR_OP_NONE, CHK_RDATA, {BOOT_ADDR, 8'h00});
    add_csr("unmapped_read", 12'h7C0, '0, CSR_OP_NONE, CHK_RDATA, '0);
    req        = csr_cmd(`CSR_MEPC, '0, CSR_OP_NONE);
    req.access = 1'b0;
    add_step(req, '0, '0, CHK_RDATA, '0, "no_access_read");
    // trap entry, load_event beats save_if
    add_csr("mie_set", `CSR_MSTATUS, 32'h1 << `MSTATUS_MIE_BIT, CSR_OP_SET, CHK_RDATA, '0);
    add_csr("mstatus_mie", `CSR_MSTATUS, '0, CSR_OP_NONE, CHK_RDATA, 32'h0000_0008);
    trap            = '0;
    trap.save_cause = 1'b1;
    trap.cause      = 6'h25;
    trap.save_if    = 1'b1;
    trap.load_event = 1'b1;
    trap.pc_if      = 32'h0000_4A18;
    trap.pc_id      = 32'h0000_4A14;
    trap.pc_ex      = PC_EX;
    add_step('0, trap, '0, CHK_IRQ, 32'h1, "trap_entry");
    add_idle("trap_irq_off", CHK_IRQ, '0);
    add_csr("trap_mepc", `CSR_MEPC, '0, CSR_OP_NONE, CHK_RDATA, PC_EX);
    add_csr("trap_mcause", `CSR_MCAUSE, '0, CSR_OP_NONE, CHK_RDATA, 32'h8000_0005);
    add_csr("trap_mstatus", `CSR_MSTATUS, '0, CSR_OP_NONE, CHK_RDATA, 32'h0000_0080);
    // return from trap
    trap      = '0;
    trap.mret = 1'b1;
    add_step('0, trap, '0, CHK_IRQ, '0, "mret");
    add_idle("mret_irq_on", CHK_IRQ, 32'h1);
    add_csr("mret_mstatus", `CSR_MSTATUS, '0, CSR_OP_NONE, CHK_RDATA, 32'h0000_0088);
    add_idle("mret_epc", CHK_EPC, PC_EX);
    // load counter only, stores must stay at zero
    add_csr("pcer_load", `CSR_PCER, 32'h1 << `PERF_LOAD, CSR_OP_WRITE, CHK_NONE, '0);
    add_csr("pcer_readback", `CSR_PCER, '0, CSR_OP_NONE, CHK_RDATA, 32'h1 << `PERF_LOAD);
    evt           = '0;
    evt.mem_load  = 1'b1;
    evt.mem_store = 1'b1;
    for (int k = 0; k < N_LOADS; k++)
      add_step('0, '0, evt, CHK_NONE, '0, "load_events");
    // event to counter takes two edges
    add_idle("load_drain", CHK_NONE, '0);
    add_idle("load_drain", CHK_NONE, '0);
    add_csr("load_count", `CSR_ADDR_W'(`CSR_PCCR_BASE + `PERF_LOAD), '0, CSR_OP_NONE,
            CHK_RDATA, `CSR_XLEN'(N_LOADS));
    add_csr("store_count", `CSR_ADDR_W'(`CSR_PCCR_BASE + `PERF_STORE), '0, CSR_OP_NONE,
            CHK_RDATA, '0);
    // cycle counter, saturate then wrap then freeze
    add_csr("pcer_cycles", `CSR_PCER, (32'h1 << `PERF_CYCLES) | (32'h1 << `PERF_LOAD),
            CSR_OP_WRITE, CHK_NONE, '0);
    add_csr("cyc_write_ones", cyc_addr, '1, CSR_OP_WRITE, CHK_RDATA, '0);
    add_csr("cyc_saturated", cyc_addr, '0, CSR_OP_NONE, CHK_RDATA, '1);
    add_csr("pcmr_wrap_mode", `CSR_PCMR, 32'h1, CSR_OP_WRITE, CHK_RDATA, 32'h3);
    // first edge after the mode write still saturates
    add_csr("cyc_sat_hold", cyc_addr, '0, CSR_OP_NONE, CHK_RDATA, '1);
    add_csr("pcmr_readback", `CSR_PCMR, '0, CSR_OP_NONE, CHK_RDATA, 32'h1);
    // wrapped to 0, then one more cycle counted
    add_csr("cyc_wrapped", cyc_addr, '0, CSR_OP_NONE, CHK_RDATA, 32'h1);
    // at 2 now, two requests still in flight
    add_csr("pcmr_off", `CSR_PCMR, '0, CSR_OP_WRITE, CHK_RDATA, 32'h1);
    add_idle("freeze_drain", CHK_NONE, '0);
    add_idle("freeze_drain", CHK_NONE, '0);
    add_csr("cyc_frozen", cyc_addr, '0, CSR_OP_NONE, CHK_RDATA, 32'h4);
    add_idle("freeze_wait", CHK_NONE, '0);
    add_csr("cyc_frozen_hold", cyc_addr, '0, CSR_OP_NONE, CHK_RDATA, 32'h4);
  endtask

  task automatic check_value(input string name, input logic [`CSR_XLEN-1:0] exp,
                             input logic [`CSR_XLEN-1:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("** Error: %s expected %h actual %h", name, exp, act);
      end
  endtask

  //////////////////////////////////////////////////////////////////////
  // run
  //////////////////////////////////////////////////////////////////////

  initial begin
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    seed       = 47673;
    rst_n      = 1'b0;
    boot_addr  = BOOT_ADDR;
    csr_req    = '0;
    trap_req   = '0;
    perf_evt   = '0;
    build_table();
    max_cycles = 2 * tab_name.size() + 20;
    repeat (3) @(posedge clk);
    #10 rst_n = 1'b1;
    for (int i = 0; i < tab_name.size(); i++) begin
      @(posedge clk);
      #10;
      csr_req  = tab_req[i];
      trap_req = tab_trap[i];
      perf_evt = tab_evt[i];
      // sample just before the next edge
      #80;
      case (tab_chk[i])
        CHK_RDATA: check_value(tab_name[i], tab_exp[i], csr_rdata);
        CHK_IRQ:   check_value(tab_name[i], tab_exp[i], {31'b0, irq_enable});
        CHK_EPC:   check_value(tab_name[i], tab_exp[i], epc);
        default:   ;
      endcase
    end
    $display("checks: %0d, check errors: %0d, assertion errors: %0d",
             checks, errors, i_dut.i_csr_asserts.fail_count);
    if (errors == 0 && i_dut.i_csr_asserts.fail_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // limit from the table length
  initial begin
    @(posedge clk);
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: table not finished after %0d cycles, check errors so far: %0d",
             cycles, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* sources.f */
+incdir+common
common/csr_pkg.sv
verilog/csr_access.sv
trap/trap_csrs.sv
perf/perf_events.sv
perf/perf_counters.sv
verilog/csr_top.sv
verification/csr_asserts.sv
verification/csr_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the CSR testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f sources.f -o Vcsr_tb &&
  ./obj_dir/Vcsr_tb +verilator+error+limit+100 > sim.log 2>&1 ||
  { echo "build or simulation failed, see sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
